// ==== build.f ====
+incdir+hdl
hdl/l2_cache_pkg.sv
hdl/l2_array.sv
hdl/l2_plru.sv
hdl/l2_cache_datapath.sv
hdl/l2_cache_control.sv
hdl/l2_cache.sv
tb/l2_pmem_model.sv
tb/l2_cache_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= l2_cache_tb
FLAGS ?=
OBJ_DIR ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove build products"
	@echo "Variables: VERILATOR, TOP, FLAGS, OBJ_DIR"

test:
	$(VERILATOR) --binary --timing --assert -Mdir $(OBJ_DIR) --top-module $(TOP) -f build.f $(FLAGS)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb/l2_cache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "l2_cache_macros.svh"

module l2_cache_tb
	import l2_cache_pkg::*;
;

localparam int period = 20;
localparam int num_requests = 27;
localparam int worst_cycles = 12;  // Write-back plus allocate plus the final hit, with slack

logic clk;
logic arst_n;
logic mem_read;
logic mem_write;
lc3b_word mem_address;
lc3b_data mem_wdata;
lc3b_data mem_rdata;
logic mem_resp;
logic pmem_read;
logic pmem_write;
lc3b_word pmem_address;
lc3b_data pmem_wdata;
lc3b_data pmem_rdata;
logic pmem_resp;
int write_count;
lc3b_word last_write_address;
lc3b_data last_write_data;

int errors = 0;
int tests_run = 0;
int tests_failed = 0;
logic [31:0] lfsr = 32'hfa71;

// Reference copy of the cache contents
bit ref_valid [`L2_SETS][`L2_WAYS];
bit ref_dirty [`L2_SETS][`L2_WAYS];
l2_tag_t ref_tag [`L2_SETS][`L2_WAYS];
lc3b_data ref_data [`L2_SETS][`L2_WAYS];
bit [`L2_LRU_W-1:0] ref_lru [`L2_SETS];
lc3b_data ref_mem [lc3b_word];  // Lines written back so far
l2_tag_t evicted_tag;
bit evicted_valid = 1'b0;

l2_cache l2_cache_i
(
	.clk(clk),
	.arst_n(arst_n),
	.mem_read(mem_read),
	.mem_write(mem_write),
	.mem_address(mem_address),
	.mem_wdata(mem_wdata),
	.mem_rdata(mem_rdata),
	.mem_resp(mem_resp),
	.pmem_read(pmem_read),
	.pmem_write(pmem_write),
	.pmem_address(pmem_address),
	.pmem_wdata(pmem_wdata),
	.pmem_rdata(pmem_rdata),
	.pmem_resp(pmem_resp)
);

l2_pmem_model pmem_i
(
	.clk(clk),
	.arst_n(arst_n),
	.pmem_read(pmem_read),
	.pmem_write(pmem_write),
	.pmem_address(pmem_address),
	.pmem_wdata(pmem_wdata),
	.pmem_rdata(pmem_rdata),
	.pmem_resp(pmem_resp),
	.write_count(write_count),
	.last_write_address(last_write_address),
	.last_write_data(last_write_data)
);

initial
begin
	clk = 1'b0;
	forever #(period / 2) clk = ~clk;
end

initial
begin
	#((num_requests * worst_cycles + 20) * period);
	$display("Timeout while waiting for mem_resp");
	$display("Something failed");
	$finish;
end

// ----------------------------------------------------------------------
// Stimulus and reference helpers
// ----------------------------------------------------------------------
function automatic logic [31:0] draw_bits(input int count);
	logic [31:0] value;
	value = '0;
	for (int i = 0; i < count; i++)
	begin
		value = {value[30:0], lfsr[0]};
		lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
	end
	return value;
endfunction

function automatic lc3b_data random_line();
	lc3b_data value;
	value = '0;
	for (int i = 0; i < 4; i++)
		value = {value[95:0], draw_bits(32)};
	return value;
endfunction

function automatic lc3b_word make_address(input l2_tag_t tag, input l2_index_t index,
	input logic [`L2_OFFSET_W-1:0] offset);
	l2_addr_t a;
	a.f.tag = tag;
	a.f.index = index;
	a.f.offset = offset;
	return a.word;
endfunction

function automatic lc3b_data memory_line(input lc3b_word line);
	if (ref_mem.exists(line))
		return ref_mem[line];
	return {8{line}};
endfunction

function automatic int find_way(input l2_addr_t a);
	int way;
	way = -1;
	for (int w = `L2_WAYS - 1; w >= 0; w--)
	begin
		if (ref_valid[a.f.index][w] && ref_tag[a.f.index][w] == a.f.tag)
			way = w;
	end
	return way;
endfunction

function automatic int tree_victim(input bit [`L2_LRU_W-1:0] bits);
	if (bits[0])
		return bits[2] ? 3 : 2;
	return bits[1] ? 1 : 0;
endfunction

function automatic bit [`L2_LRU_W-1:0] tree_touch(input bit [`L2_LRU_W-1:0] bits, input int way);
	bit [`L2_LRU_W-1:0] next;
	next = bits;
	case (way)
		0: next[1:0] = 2'b11;
		1: next[1:0] = 2'b01;
		2: {next[2], next[0]} = 2'b10;
		default: {next[2], next[0]} = 2'b00;
	endcase
	return next;
endfunction

task automatic expect_value(input string name, input lc3b_data got, input lc3b_data exp);
	assert (got === exp)
	else
	begin
		$display("Error: %s is %h, expected %h", name, got, exp);
		errors++;
	end
endtask

task automatic run_request(input bit is_write, input lc3b_word address, input lc3b_data wdata);
	l2_addr_t a;
	l2_addr_t line;
	l2_addr_t wb_line;
	l2_index_t idx;
	int way;
	int victim;
	int cycles;
	int writes_before;
	bit expect_wb;
	bit saw_read;
	lc3b_data exp_data;

	a.word = address;
	idx = a.f.index;
	line = a;
	line.f.offset = '0;
	way = find_way(a);
	victim = tree_victim(ref_lru[idx]);
	expect_wb = (way < 0) && ref_valid[idx][victim] && ref_dirty[idx][victim];
	wb_line = line;
	wb_line.f.tag = ref_tag[idx][victim];
	if (way < 0)
		exp_data = memory_line(line.word);
	else
		exp_data = ref_data[idx][way];
	writes_before = write_count;

	mem_read = !is_write;
	mem_write = is_write;
	mem_address = address;
	mem_wdata = wdata;
	cycles = 0;
	saw_read = 1'b0;
	#(period / 4);
	while (!mem_resp)
	begin
		if (pmem_read)
		begin
			saw_read = 1'b1;
			expect_value("pmem_address", lc3b_data'(pmem_address), lc3b_data'(line.word));
		end
		@(negedge clk);
		#(period / 4);
		cycles++;
	end

	if (way >= 0)
	begin
		assert (cycles == 0 && !pmem_read && !pmem_write)
		else
		begin
			$display("Hit at %h took %0d cycles or used memory", address, cycles);
			errors++;
		end
	end
	else
	begin
		assert (cycles > 0 && saw_read)
		else
		begin
			$display("Miss at %h was answered without a memory read", address);
			errors++;
		end
	end
	if (!is_write)
		expect_value("mem_rdata", mem_rdata, exp_data);
	assert (write_count == writes_before + int'(expect_wb))
	else
	begin
		$display("Request to %h made %0d memory writes, expected %0d", address,
			write_count - writes_before, int'(expect_wb));
		errors++;
	end
	if (expect_wb)
	begin
		expect_value("pmem_address", lc3b_data'(last_write_address), lc3b_data'(wb_line.word));
		expect_value("pmem_wdata", last_write_data, ref_data[idx][victim]);
		ref_mem[wb_line.word] = ref_data[idx][victim];
	end

	// The miss fills the victim, then the request completes as a hit
	if (way < 0)
	begin
		if (ref_valid[idx][victim])
		begin
			evicted_tag = ref_tag[idx][victim];
			evicted_valid = 1'b1;
		end
		ref_valid[idx][victim] = 1'b1;
		ref_dirty[idx][victim] = 1'b0;
		ref_tag[idx][victim] = a.f.tag;
		ref_data[idx][victim] = exp_data;
		way = victim;
	end
	ref_lru[idx] = tree_touch(ref_lru[idx], way);
	if (is_write)
	begin
		ref_data[idx][way] = wdata;
		ref_dirty[idx][way] = 1'b1;
	end

	@(negedge clk);
	mem_read = 1'b0;
	mem_write = 1'b0;
endtask

task automatic finish_test(input string name, input int errors_before);
	tests_run++;
	if (errors == errors_before)
		$display("Test %0d %s: pass", tests_run, name);
	else
	begin
		tests_failed++;
		$display("Test %0d %s: %0d errors", tests_run, name, errors - errors_before);
	end
endtask

// ----------------------------------------------------------------------
// Test sequence
// ----------------------------------------------------------------------
initial
begin
	l2_addr_t t1;
	l2_index_t set4;
	l2_index_t set5;
	l2_tag_t base_tag;
	l2_tag_t tag;
	int errors_before;

	arst_n = 1'b0;
	mem_read = 1'b0;
	mem_write = 1'b0;
	mem_address = '0;
	mem_wdata = '0;
	repeat (4) @(posedge clk);
	@(negedge clk);
	arst_n = 1'b1;
	@(negedge clk);

	errors_before = errors;
	t1.word = lc3b_word'(draw_bits(16));
	run_request(1'b0, t1.word, '0);
	finish_test("cold miss", errors_before);

	errors_before = errors;
	run_request(1'b0, t1.word, '0);
	run_request(1'b0, make_address(t1.f.tag, t1.f.index, ~t1.f.offset), '0);
	finish_test("repeat read hit", errors_before);

	errors_before = errors;
	run_request(1'b1, t1.word, random_line());
	run_request(1'b0, t1.word, '0);
	finish_test("write then read", errors_before);

	// Fill one set, churn it with random tags, then probe survivors and the victim
	errors_before = errors;
	set4 = t1.f.index + 4'd1;
	base_tag = l2_tag_t'(draw_bits(8));
	for (int i = 0; i < 4; i++)
		run_request(1'b0, make_address(l2_tag_t'(base_tag + i), set4, 4'h0), '0);
	for (int i = 0; i < 6; i++)
	begin
		tag = l2_tag_t'(draw_bits(8));
		run_request(1'b0, make_address(tag, set4, 4'h0), '0);
	end
	for (int w = 0; w < `L2_WAYS; w++)
		run_request(1'b0, make_address(ref_tag[set4][w], set4, 4'h0), '0);
	if (evicted_valid)
		run_request(1'b0, make_address(evicted_tag, set4, 4'h0), '0);
	finish_test("replacement order", errors_before);

	errors_before = errors;
	set5 = t1.f.index + 4'd2;
	base_tag = l2_tag_t'(draw_bits(8));
	for (int i = 0; i < 4; i++)
		run_request(1'b1, make_address(l2_tag_t'(base_tag + i), set5, 4'h0), random_line());
	for (int i = 4; i < 6; i++)
		run_request(1'b0, make_address(l2_tag_t'(base_tag + i), set5, 4'h0), '0);
	run_request(1'b0, make_address(evicted_tag, set5, 4'h0), '0);
	finish_test("dirty write-back", errors_before);

	$display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
	if (errors == 0)
		$display("Everything OK");
	else
		$display("Something failed");
	$finish;
end

endmodule: l2_cache_tb

`default_nettype wire

// ==== tb/l2_pmem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module l2_pmem_model
	import l2_cache_pkg::*;
#(
	parameter int latency = 3
)
(
	input  logic clk,
	input  logic arst_n,
	input  logic pmem_read,
	input  logic pmem_write,
	input  lc3b_word pmem_address,
	input  lc3b_data pmem_wdata,
	output lc3b_data pmem_rdata,
	output logic pmem_resp,
	output int write_count,
	output lc3b_word last_write_address,
	output lc3b_data last_write_data
);

lc3b_data lines [4096];
bit written [4096];
int wait_count;
logic done;

// The request level has been held for the full latency
assign done = (pmem_read || pmem_write) && !pmem_resp && (wait_count == latency - 1);

always_ff @(posedge clk or negedge arst_n)
begin
	if (!arst_n)
	begin
		wait_count <= 0;
		pmem_resp <= 1'b0;
		pmem_rdata <= '0;
		write_count <= 0;
		last_write_address <= '0;
		last_write_data <= '0;
	end
	else
	begin
		pmem_resp <= done;
		if (done)
		begin
			wait_count <= 0;
			if (pmem_write)
			begin
				write_count <= write_count + 1;
				last_write_address <= pmem_address;
				last_write_data <= pmem_wdata;
			end
			else if (written[pmem_address[15:4]])
				pmem_rdata <= lines[pmem_address[15:4]];
			else
				pmem_rdata <= {8{pmem_address}};  // Unwritten lines repeat their address
		end
		else if ((pmem_read || pmem_write) && !pmem_resp)
			wait_count <= wait_count + 1;
	end
end

always_ff @(posedge clk)
begin
	if (done && pmem_write)
	begin
		lines[pmem_address[15:4]] <= pmem_wdata;
		written[pmem_address[15:4]] <= 1'b1;
	end
end

endmodule: l2_pmem_model

`default_nettype wire

// ==== hdl/l2_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

module l2_cache
	import l2_cache_pkg::*;
(
	input  logic clk,
	input  logic arst_n,

	// Upper side
	input  logic mem_read,
	input  logic mem_write,
	input  lc3b_word mem_address,
	input  lc3b_data mem_wdata,
	output lc3b_data mem_rdata,
	output logic mem_resp,

	// Physical memory side
	output logic pmem_read,
	output logic pmem_write,
	output lc3b_word pmem_address,
	output lc3b_data pmem_wdata,
	input  lc3b_data pmem_rdata,
	input  logic pmem_resp
);

logic hit;
logic victim_dirty;
logic data_write;
logic dirty_write;
logic dirty_in;
logic fill;
logic lru_write;
logic wb_sel;

l2_cache_control control_i
(
	.clk(clk),
	.arst_n(arst_n),
	.mem_read(mem_read),
	.mem_write(mem_write),
	.hit(hit),
	.victim_dirty(victim_dirty),
	.pmem_resp(pmem_resp),
	.mem_resp(mem_resp),
	.data_write(data_write),
	.dirty_write(dirty_write),
	.dirty_in(dirty_in),
	.fill(fill),
	.lru_write(lru_write),
	.wb_sel(wb_sel),
	.pmem_read(pmem_read),
	.pmem_write(pmem_write)
);

l2_cache_datapath datapath_i
(
	.clk(clk),
	.arst_n(arst_n),
	.mem_address(mem_address),
	.mem_wdata(mem_wdata),
	.pmem_rdata(pmem_rdata),
	.data_write(data_write),
	.dirty_write(dirty_write),
	.dirty_in(dirty_in),
	.fill(fill),
	.lru_write(lru_write),
	.wb_sel(wb_sel),
	.hit(hit),
	.victim_dirty(victim_dirty),
	.mem_rdata(mem_rdata),
	.pmem_wdata(pmem_wdata),
	.pmem_address(pmem_address)
);

endmodule: l2_cache

`default_nettype wire

// ==== hdl/l2_cache_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module l2_cache_control
(
	input  logic clk,
	input  logic arst_n,
	input  logic mem_read,
	input  logic mem_write,
	input  logic hit,
	input  logic victim_dirty,
	input  logic pmem_resp,
	output logic mem_resp,
	output logic data_write,
	output logic dirty_write,
	output logic dirty_in,
	output logic fill,
	output logic lru_write,
	output logic wb_sel,
	output logic pmem_read,
	output logic pmem_write
);

localparam logic [1:0] check = 2'd0;
localparam logic [1:0] write_back = 2'd1;
localparam logic [1:0] allocate = 2'd2;

logic [1:0] state;
logic [1:0] state_next;

// ----------------------------------------------------------------------
// State register
// ----------------------------------------------------------------------
always_ff @(posedge clk or negedge arst_n)
begin
	if (!arst_n)
		state <= check;
	else
		state <= state_next;
end

// ----------------------------------------------------------------------
// Outputs and next state
// ----------------------------------------------------------------------
always_comb
begin
	state_next = state;
	mem_resp = 1'b0;
	data_write = 1'b0;
	dirty_write = 1'b0;
	dirty_in = 1'b0;
	fill = 1'b0;
	lru_write = 1'b0;
	wb_sel = 1'b0;
	pmem_read = 1'b0;
	pmem_write = 1'b0;

	case (state)
		check:
		begin
			if (mem_read || mem_write)
			begin
				if (hit)
				begin
					mem_resp = 1'b1;  // Hit answers in the same cycle
					lru_write = 1'b1;
					if (mem_write)
					begin
						data_write = 1'b1;
						dirty_write = 1'b1;
						dirty_in = 1'b1;
					end
				end
				else if (victim_dirty)
					state_next = write_back;
				else
					state_next = allocate;
			end
		end

		write_back:
		begin
			pmem_write = 1'b1;
			wb_sel = 1'b1;
			if (pmem_resp)
				state_next = allocate;
		end

		allocate:
		begin
			pmem_read = 1'b1;
			if (pmem_resp)
			begin
				fill = 1'b1;  // Line is written at this edge, request then hits in check
				state_next = check;
			end
		end

		default: state_next = check;
	endcase
end

endmodule: l2_cache_control

`default_nettype wire

// ==== hdl/l2_cache_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "l2_cache_macros.svh"

module l2_cache_datapath
	import l2_cache_pkg::*;
(
	input  logic clk,
	input  logic arst_n,
	input  lc3b_word mem_address,
	input  lc3b_data mem_wdata,
	input  lc3b_data pmem_rdata,
	input  logic data_write,
	input  logic dirty_write,
	input  logic dirty_in,
	input  logic fill,
	input  logic lru_write,
	input  logic wb_sel,
	output logic hit,
	output logic victim_dirty,
	output lc3b_data mem_rdata,
	output lc3b_data pmem_wdata,
	output lc3b_word pmem_address
);

l2_addr_t addr;
l2_addr_t line_addr;

logic [`L2_WAYS-1:0] valid_out;
logic [`L2_WAYS-1:0] dirty_out;
logic [`L2_WAYS-1:0] way_hit;
logic [`L2_WAYS-1:0] way_sel;
l2_tag_t tag_out [`L2_WAYS];
lc3b_data data_out [`L2_WAYS];

logic [`L2_LRU_W-1:0] lru_out;
logic [`L2_LRU_W-1:0] lru_next;
l2_way_t hit_way;
l2_way_t victim_way;
l2_way_t sel_way;

assign addr.word = mem_address;

// ----------------------------------------------------------------------
// Per-way storage
// ----------------------------------------------------------------------
assign sel_way = fill ? victim_way : hit_way;  // Fill targets the victim, all else the hit way

generate
	for (genvar w = 0; w < `L2_WAYS; w++)
	begin : g_way
		assign way_sel[w] = (sel_way == l2_way_t'(w));

		l2_array #(.width(1), .clear_on_reset(1'b1)) valid_i
		(
			.clk(clk),
			.arst_n(arst_n),
			.write(fill & way_sel[w]),
			.index(addr.f.index),
			.datain(1'b1),
			.dataout(valid_out[w])
		);

		l2_array #(.width(1), .clear_on_reset(1'b1)) dirty_i
		(
			.clk(clk),
			.arst_n(arst_n),
			.write((fill | dirty_write) & way_sel[w]),
			.index(addr.f.index),
			.datain(dirty_in & ~fill),  // A fresh line is clean
			.dataout(dirty_out[w])
		);

		l2_array #(.width(`L2_TAG_W), .clear_on_reset(1'b0)) tag_i
		(
			.clk(clk),
			.arst_n(arst_n),
			.write(fill & way_sel[w]),
			.index(addr.f.index),
			.datain(addr.f.tag),
			.dataout(tag_out[w])
		);

		l2_array #(.width(`L2_LINE_W), .clear_on_reset(1'b0)) data_i
		(
			.clk(clk),
			.arst_n(arst_n),
			.write((fill | data_write) & way_sel[w]),
			.index(addr.f.index),
			.datain(fill ? pmem_rdata : mem_wdata),
			.dataout(data_out[w])
		);

		assign way_hit[w] = valid_out[w] & (tag_out[w] == addr.f.tag);
	end
endgenerate

// ----------------------------------------------------------------------
// Replacement state
// ----------------------------------------------------------------------
l2_array #(.width(`L2_LRU_W), .clear_on_reset(1'b1)) lru_i
(
	.clk(clk),
	.arst_n(arst_n),
	.write(lru_write),
	.index(addr.f.index),
	.datain(lru_next),
	.dataout(lru_out)
);

l2_plru plru_i
(
	.lru_bits(lru_out),
	.access_way(sel_way),
	.victim_way(victim_way),
	.lru_next(lru_next)
);

// Lowest matching way wins
always_comb
begin
	hit_way = '0;
	for (int w = `L2_WAYS - 1; w >= 0; w--)
	begin
		if (way_hit[w])
			hit_way = l2_way_t'(w);
	end
end

assign hit = |way_hit;
assign mem_rdata = data_out[hit_way];
assign victim_dirty = dirty_out[victim_way];
assign pmem_wdata = data_out[victim_way];

// Line address towards memory, write-back uses the victim's tag
always_comb
begin
	line_addr.f.tag = wb_sel ? tag_out[victim_way] : addr.f.tag;
	line_addr.f.index = addr.f.index;
	line_addr.f.offset = '0;
end

assign pmem_address = line_addr.word;

endmodule: l2_cache_datapath

`default_nettype wire

// ==== hdl/l2_plru.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "l2_cache_macros.svh"

module l2_plru
	import l2_cache_pkg::*;
(
	input  logic [`L2_LRU_W-1:0] lru_bits,
	input  l2_way_t access_way,
	output l2_way_t victim_way,
	output logic [`L2_LRU_W-1:0] lru_next
);

// Bit 0 chooses the pair, bits 1 and 2 choose the way inside it
assign victim_way = lru_bits[0] ? {1'b1, lru_bits[2]} : {1'b0, lru_bits[1]};

// Point the tree away from the way just used
always_comb
begin
	case (access_way)
		2'd0: lru_next = {lru_bits[2], 1'b1, 1'b1};
		2'd1: lru_next = {lru_bits[2], 1'b0, 1'b1};
		2'd2: lru_next = {1'b1, lru_bits[1], 1'b0};
		default: lru_next = {1'b0, lru_bits[1], 1'b0};
	endcase
end

endmodule: l2_plru

`default_nettype wire

// ==== hdl/l2_array.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "l2_cache_macros.svh"

module l2_array
	import l2_cache_pkg::*;
#(
	parameter int width = 1,
	parameter bit clear_on_reset = 1'b0
)
(
	input  logic clk,
	input  logic arst_n,
	input  logic write,
	input  l2_index_t index,
	input  logic [width-1:0] datain,
	output logic [width-1:0] dataout
);

logic [width-1:0] mem [`L2_SETS];

generate
	if (clear_on_reset)
	begin : g_clear
		// Control arrays start out empty
		always_ff @(posedge clk or negedge arst_n)
		begin
			if (!arst_n)
			begin
				for (int i = 0; i < `L2_SETS; i++)
					mem[i] <= '0;
			end
			else if (write)
				mem[index] <= datain;
		end
	end
	else
	begin : g_plain
		always_ff @(posedge clk)
		begin
			if (write)
				mem[index] <= datain;
		end
	end
endgenerate

assign dataout = mem[index];  // Read is asynchronous

endmodule: l2_array

`default_nettype wire

// ==== hdl/l2_cache_pkg.sv ====
`default_nettype none

`include "l2_cache_macros.svh"

package l2_cache_pkg;

	typedef logic [15:0] lc3b_word;
	typedef logic [`L2_LINE_W-1:0] lc3b_data;  // 8 words

	typedef logic [`L2_TAG_W-1:0] l2_tag_t;
	typedef logic [`L2_INDEX_W-1:0] l2_index_t;
	typedef logic [$clog2(`L2_WAYS)-1:0] l2_way_t;

	// The request address, read as a whole word or split into its cache fields
	typedef union packed {
		lc3b_word word;
		struct packed {
			l2_tag_t tag;  // Bits 15 to 8
			l2_index_t index;  // Bits 7 to 4
			logic [`L2_OFFSET_W-1:0] offset;
		} f;
	} l2_addr_t;

endpackage: l2_cache_pkg

`default_nettype wire

// ==== hdl/l2_cache_macros.svh ====
`ifndef L2_CACHE_MACROS_SVH
`define L2_CACHE_MACROS_SVH

// Cache geometry, 4 ways of 16 sets with 128-bit lines
`define L2_WAYS      4
`define L2_SETS      16

// Address fields of the 16-bit request word
`define L2_TAG_W     8
`define L2_INDEX_W   4
`define L2_OFFSET_W  4

`define L2_LINE_W    128
`define L2_LRU_W     3  // Pseudo-LRU tree bits per set

`endif
